// File: verilog/kpu_defines.svh
`ifndef KPU_DEFINES_SVH
`define KPU_DEFINES_SVH

// Architectural register count
`define KPU_NUM_REGS 32

// Data memory size in 32-bit words
`define KPU_MEM_DEPTH 256

`endif

// File: verilog/kpu_pkg.sv
package kpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [15:0] imm_t;

  // Flag vector, z in bit 2, c in bit 1, n in bit 0
  typedef logic [2:0] flags_t;

  // Unlisted encodings are no-ops
  typedef enum logic [5:0] {
    OP_LDI = 6'h01,
    OP_ADD = 6'h02,
    OP_SUB = 6'h03,
    OP_AND = 6'h04,
    OP_OR  = 6'h05,
    OP_XOR = 6'h06,
    OP_SHL = 6'h07,
    OP_SHR = 6'h08,
    OP_SRA = 6'h09,
    OP_LD  = 6'h0a,
    OP_ST  = 6'h0b,
    OP_OUT = 6'h0c
  } opcode_e;

  typedef enum logic [2:0] {
    MLU_ADD, MLU_SUB, MLU_AND, MLU_OR, MLU_XOR, MLU_SHL, MLU_SHR, MLU_SRA
  } mlu_op_e;

  typedef enum logic [2:0] {
    BUS_NONE, BUS_INSTR, BUS_REG, BUS_TMP0, BUS_MLU, BUS_MEM, BUS_IMM
  } bus_src_e;

  typedef enum logic [1:0] {
    ST_IDLE, ST_STEP1, ST_STEP2, ST_STEP3
  } ctrl_state_e;

endpackage

// File: verilog/kpu_ctrl_if.sv
`timescale 1ns/1ps

interface kpu_ctrl_if;
  import kpu_pkg::*;

  // Out plane and in plane
  bus_src_e bus_src;
  logic reg_sel;  // 0 picks src0, 1 picks src1
  logic reg_we;
  logic tmp0_we;
  logic tmp1_we;
  logic opword_we;
  logic mem_we;
  mlu_op_e mlu_op;
  logic out_valid;

  // Decoded opword fields
  opcode_e opcode;
  reg_idx_t src0;
  reg_idx_t src1;

  modport control (
    output bus_src, reg_sel, reg_we, tmp0_we, tmp1_we, opword_we, mem_we, mlu_op, out_valid,
    input opcode, src0, src1
  );

  modport datapath (
    input bus_src, reg_sel, reg_we, tmp0_we, tmp1_we, opword_we, mem_we, mlu_op,
    output opcode, src0, src1
  );

endinterface

// File: verilog/mlu.sv
`timescale 1ns/1ps

module mlu (
  input logic clk,
  input logic rst_n,
  input kpu_pkg::word_t a,
  input kpu_pkg::word_t b,
  input kpu_pkg::mlu_op_e op,
  input logic flags_we,
  output kpu_pkg::word_t result,
  output kpu_pkg::flags_t flags
);
  import kpu_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic [4:0] shamt;
  logic carry;

  assign sum = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];

  always_comb begin
    carry = 1'b0;
    case (op)
      MLU_ADD: begin
        result = sum[31:0];
        carry = sum[32];
      end
      MLU_SUB: begin
        result = diff[31:0];
        carry = ~diff[32];  // no borrow means a >= b
      end
      MLU_AND: result = a & b;
      MLU_OR: result = a | b;
      MLU_XOR: result = a ^ b;
      MLU_SHL: result = a << shamt;
      MLU_SHR: result = a >> shamt;
      default: result = word_t'($signed(a) >>> shamt);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flags_we) begin
      flags <= {result == '0, carry, result[31]};
    end
  end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "kpu_defines.svh"

module register_file (
  input logic clk,
  input logic rst_n,
  input kpu_pkg::reg_idx_t rd_idx,
  input kpu_pkg::reg_idx_t wr_idx,
  input kpu_pkg::word_t wr_data,
  input logic we,
  output kpu_pkg::word_t rd_data
);
  import kpu_pkg::*;

  word_t gpr [`KPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `KPU_NUM_REGS; i++) begin
        gpr[i] <= '0;
      end
    end else if (we) begin
      gpr[wr_idx] <= wr_data;
    end
  end

  // Combinational read
  assign rd_data = gpr[rd_idx];

endmodule

// File: verilog/mmu.sv
`timescale 1ns/1ps
`include "kpu_defines.svh"

module mmu (
  input logic clk,
  input kpu_pkg::word_t addr,
  input kpu_pkg::word_t wr_data,
  input logic we,
  output kpu_pkg::word_t rd_data
);
  import kpu_pkg::*;

  localparam int ADDR_W = $clog2(`KPU_MEM_DEPTH);

  word_t mem [`KPU_MEM_DEPTH];
  logic [ADDR_W-1:0] index;

  // Upper address bits wrap
  assign index = addr[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wr_data;
    end
  end

  assign rd_data = mem[index];

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
  input logic clk,
  input logic rst_n,
  input kpu_pkg::word_t instr,
  output kpu_pkg::word_t bus,
  output kpu_pkg::flags_t flags,
  kpu_ctrl_if.datapath ctrl
);
  import kpu_pkg::*;

  word_t opword_q;
  word_t tmp0_q;
  word_t tmp1_q;
  word_t reg_rd_data;
  word_t mlu_result;
  word_t mem_rd_data;
  imm_t imm;
  reg_idx_t reg_idx;
  logic flags_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opword_q <= '0;
    end else if (ctrl.opword_we) begin
      opword_q <= bus;
    end
  end

  // Scratch registers, not visible to the program
  always_ff @(posedge clk) begin
    if (ctrl.tmp0_we) begin
      tmp0_q <= bus;
    end
    if (ctrl.tmp1_we) begin
      tmp1_q <= bus;
    end
  end

  // Sequencer sees the incoming opcode during the accept cycle
  assign ctrl.opcode = opcode_e'(ctrl.opword_we ? instr[5:0] : opword_q[5:0]);
  assign ctrl.src0 = opword_q[10:6];
  assign ctrl.src1 = opword_q[15:11];
  assign imm = opword_q[31:16];

  assign reg_idx = ctrl.reg_sel ? ctrl.src1 : ctrl.src0;
  assign flags_we = ctrl.reg_we && (ctrl.bus_src == BUS_MLU);

  always_comb begin
    case (ctrl.bus_src)
      BUS_INSTR: bus = instr;
      BUS_REG: bus = reg_rd_data;
      BUS_TMP0: bus = tmp0_q;
      BUS_MLU: bus = mlu_result;
      BUS_MEM: bus = mem_rd_data;
      BUS_IMM: bus = {16'b0, imm};
      default: bus = '0;
    endcase
  end

  register_file regs (
    .clk(clk),
    .rst_n(rst_n),
    .rd_idx(reg_idx),
    .wr_idx(reg_idx),
    .wr_data(bus),
    .we(ctrl.reg_we),
    .rd_data(reg_rd_data)
  );

  mlu mlu_unit (
    .clk(clk),
    .rst_n(rst_n),
    .a(tmp0_q),
    .b(tmp1_q),
    .op(ctrl.mlu_op),
    .flags_we(flags_we),
    .result(mlu_result),
    .flags(flags)
  );

  // Memory is addressed through tmp0
  mmu mmu_unit (
    .clk(clk),
    .addr(tmp0_q),
    .wr_data(bus),
    .we(ctrl.mem_we),
    .rd_data(mem_rd_data)
  );

endmodule

// File: verilog/control_logic.sv
`timescale 1ns/1ps

module control_logic (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  output logic ready,
  kpu_ctrl_if.control ctrl
);
  import kpu_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic [1:0] steps;

  // Micro-steps each opcode needs after the accept cycle
  always_comb begin
    case (ctrl.opcode)
      OP_LDI, OP_OUT: steps = 2'd1;
      OP_LD, OP_ST: steps = 2'd2;
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SRA: steps = 2'd3;
      default: steps = 2'd0;
    endcase
  end

  always_comb begin
    case (ctrl.opcode)
      OP_SUB: ctrl.mlu_op = MLU_SUB;
      OP_AND: ctrl.mlu_op = MLU_AND;
      OP_OR: ctrl.mlu_op = MLU_OR;
      OP_XOR: ctrl.mlu_op = MLU_XOR;
      OP_SHL: ctrl.mlu_op = MLU_SHL;
      OP_SHR: ctrl.mlu_op = MLU_SHR;
      OP_SRA: ctrl.mlu_op = MLU_SRA;
      default: ctrl.mlu_op = MLU_ADD;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      // Unknown opcodes are swallowed in the accept cycle
      ST_IDLE: if (instr_valid && steps != 2'd0) state_next = ST_STEP1;
      ST_STEP1: state_next = (steps > 2'd1) ? ST_STEP2 : ST_IDLE;
      ST_STEP2: state_next = (steps > 2'd2) ? ST_STEP3 : ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign ready = (state == ST_IDLE);

  // Opword latches the instruction on the accept edge
  assign ctrl.opword_we = (state == ST_IDLE) && instr_valid;

  // One bus source per step and the latch enables that go with it
  always_comb begin
    ctrl.bus_src = BUS_NONE;
    ctrl.reg_sel = 1'b0;
    ctrl.reg_we = 1'b0;
    ctrl.tmp0_we = 1'b0;
    ctrl.tmp1_we = 1'b0;
    ctrl.mem_we = 1'b0;
    ctrl.out_valid = 1'b0;
    case (state)
      ST_IDLE: begin
        if (instr_valid) begin
          ctrl.bus_src = BUS_INSTR;
        end
      end
      ST_STEP1: begin
        case (ctrl.opcode)
          OP_LDI: begin
            ctrl.bus_src = BUS_IMM;
            ctrl.reg_we = 1'b1;
          end
          OP_OUT: begin
            ctrl.bus_src = BUS_REG;
            ctrl.out_valid = 1'b1;
          end
          // LD, ST and MLU ops stage src0 in tmp0
          default: begin
            ctrl.bus_src = BUS_REG;
            ctrl.tmp0_we = 1'b1;
          end
        endcase
      end
      ST_STEP2: begin
        ctrl.reg_sel = 1'b1;
        case (ctrl.opcode)
          OP_LD: begin
            ctrl.bus_src = BUS_MEM;
            ctrl.reg_we = 1'b1;
          end
          OP_ST: begin
            ctrl.bus_src = BUS_REG;
            ctrl.mem_we = 1'b1;
          end
          default: begin
            ctrl.bus_src = BUS_REG;
            ctrl.tmp1_we = 1'b1;
          end
        endcase
      end
      default: begin
        // Writeback of the MLU result into src0
        ctrl.bus_src = BUS_MLU;
        ctrl.reg_we = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/kpu.sv
`timescale 1ns/1ps

module kpu (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input kpu_pkg::word_t instr,
  output logic ready,
  output kpu_pkg::word_t bus,
  output logic out_valid,
  output kpu_pkg::flags_t flags
);

  kpu_ctrl_if ctrl_if ();

  control_logic control (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .ready(ready),
    .ctrl(ctrl_if.control)
  );

  datapath dp (
    .clk(clk),
    .rst_n(rst_n),
    .instr(instr),
    .bus(bus),
    .flags(flags),
    .ctrl(ctrl_if.datapath)
  );

  // OUT strobe goes straight from the sequencer
  assign out_valid = ctrl_if.out_valid;

endmodule

// File: sim/kpu_properties.sv
`timescale 1ns/1ps

module kpu_properties (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input kpu_pkg::word_t instr,
  input logic ready,
  input logic out_valid
);
  import kpu_pkg::*;

  logic known_op;

  // Opcodes that start a micro-sequence
  always_comb begin
    case (instr[5:0])
      OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_SHL, OP_SHR, OP_SRA, OP_LD, OP_ST, OP_OUT: known_op = 1'b1;
      default: known_op = 1'b0;
    endcase
  end

  out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else $error("out_valid stayed high for more than one cycle");

  accept_drops_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid && ready && known_op) |=> !ready)
    else $error("ready did not fall after an accepted instruction");

  ready_out_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(ready && out_valid))
    else $error("ready and out_valid high in the same cycle");

endmodule

// File: sim/kpu_tb.sv
`timescale 1ns/1ps
`include "kpu_defines.svh"

module kpu_tb;
  import kpu_pkg::*;

  localparam logic [1:0] K_NONE = 2'd0;
  localparam logic [1:0] K_WORD = 2'd1;
  localparam logic [1:0] K_WORD_FLAGS = 2'd2;
  localparam int MEM_AW = $clog2(`KPU_MEM_DEPTH);

  // One instruction and the response it should give
  typedef struct packed {
    word_t instr;
    logic [1:0] kind;
    word_t exp_word;
    flags_t exp_flags;
    logic busy;
    logic poke;
  } row_t;

  logic clk;
  logic rst_n;
  logic instr_valid;
  word_t instr;
  logic ready;
  word_t bus;
  logic out_valid;
  flags_t flags;

  row_t rows[$];
  word_t model_regs [`KPU_NUM_REGS];
  word_t model_mem [`KPU_MEM_DEPTH];
  word_t poke_instr;
  logic poke_next;
  integer seed;
  int cycles;
  int cycle_limit;

  kpu kpu_inst (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr(instr),
    .ready(ready),
    .bus(bus),
    .out_valid(out_valid),
    .flags(flags)
  );

  bind kpu kpu_properties kpu_props (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr(instr),
    .ready(ready),
    .out_valid(out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout after %0d cycles, the core stopped making progress", cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
      end
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t want);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s = %b, expected %b (z c n)", $time, name, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  function automatic word_t encode(input logic [5:0] op, input reg_idx_t s0,
                                   input reg_idx_t s1, input imm_t imm);
    return {imm, s1, s0, op};
  endfunction

  function automatic logic [MEM_AW-1:0] mem_index(input word_t addr);
    return addr[MEM_AW-1:0];
  endfunction

  task automatic push_row(input word_t ins, input logic [1:0] kind, input word_t w,
                          input flags_t f, input logic busy);
    row_t r;
    r.instr = ins;
    r.kind = kind;
    r.exp_word = w;
    r.exp_flags = f;
    r.busy = busy;
    r.poke = poke_next;
    rows.push_back(r);
    poke_next = 1'b0;
  endtask

  task automatic add_ldi(input reg_idx_t rd, input imm_t imm);
    model_regs[rd] = {16'h0000, imm};
    push_row(encode(OP_LDI, rd, 5'd0, imm), K_NONE, '0, '0, 1'b1);
  endtask

  task automatic add_out(input reg_idx_t rs);
    push_row(encode(OP_OUT, rs, 5'd0, 16'h0000), K_WORD, model_regs[rs], '0, 1'b1);
  endtask

  task automatic add_st(input reg_idx_t ra, input reg_idx_t rv);
    model_mem[mem_index(model_regs[ra])] = model_regs[rv];
    push_row(encode(OP_ST, ra, rv, 16'h0000), K_NONE, '0, '0, 1'b1);
  endtask

  task automatic add_ld(input reg_idx_t ra, input reg_idx_t rd);
    model_regs[rd] = model_mem[mem_index(model_regs[ra])];
    push_row(encode(OP_LD, ra, rd, 16'h0000), K_NONE, '0, '0, 1'b1);
  endtask

  // Reference model of the MLU ops with the result in rd
  task automatic add_alu(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs);
    word_t a;
    word_t b;
    word_t res;
    logic c;
    logic [4:0] sh;
    a = model_regs[rd];
    b = model_regs[rs];
    sh = b[4:0];
    c = 1'b0;
    case (op)
      OP_ADD: begin
        res = a + b;
        c = (res < a);
      end
      OP_SUB: begin
        res = a - b;
        c = (a >= b);
      end
      OP_AND: res = a & b;
      OP_OR: res = a | b;
      OP_XOR: res = a ^ b;
      OP_SHL: res = a << sh;
      OP_SHR: res = a >> sh;
      default: res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
    endcase
    model_regs[rd] = res;
    push_row(encode(op, rd, rs, 16'h0000), K_WORD_FLAGS, res, {res == '0, c, res[31]}, 1'b1);
  endtask

  // Full 32-bit constant through LDI, SHL and OR with r31 as scratch
  task automatic load_word(input reg_idx_t rd, input word_t v);
    add_ldi(rd, v[31:16]);
    add_ldi(5'd31, 16'd16);
    add_alu(OP_SHL, rd, 5'd31);
    add_ldi(5'd31, v[15:0]);
    add_alu(OP_OR, rd, 5'd31);
  endtask

  task automatic random_alu(input opcode_e op);
    load_word(5'd2, $random(seed));
    load_word(5'd3, $random(seed));
    add_alu(op, 5'd2, 5'd3);
    add_out(5'd2);
  endtask

  // Negative operands so SRA fill is visible
  task automatic shift_set(input imm_t amt);
    load_word(5'd8, $random(seed) | 32'h8000_0000);
    add_ldi(5'd9, amt);
    add_alu(OP_SHL, 5'd8, 5'd9);
    add_out(5'd8);
    load_word(5'd8, $random(seed) | 32'h8000_0000);
    add_alu(OP_SHR, 5'd8, 5'd9);
    add_out(5'd8);
    load_word(5'd8, $random(seed) | 32'h8000_0000);
    add_alu(OP_SRA, 5'd8, 5'd9);
    add_out(5'd8);
  endtask

  task automatic memory_test();
    imm_t addrs[$];
    imm_t a;
    reg_idx_t dst;
    repeat (4) begin
      a = imm_t'($random(seed));
      addrs.push_back(a);
      add_ldi(5'd10, a);
      load_word(5'd11, $random(seed));
      add_st(5'd10, 5'd11);
    end
    dst = 5'd12;
    while (addrs.size() > 0) begin
      add_ldi(5'd10, addrs.pop_front());
      add_ld(5'd10, dst);
      add_out(dst);
      dst = dst + 5'd1;
    end
  endtask

  task automatic build_table();
    word_t v;
    seed = 32'h2e89;
    poke_next = 1'b0;
    model_regs = '{default: '0};
    poke_instr = encode(OP_LDI, 5'd2, 5'd0, 16'h1234);
    add_ldi(5'd1, 16'hbeef);
    add_out(5'd1);
    random_alu(OP_ADD);
    random_alu(OP_SUB);
    random_alu(OP_AND);
    random_alu(OP_OR);
    random_alu(OP_XOR);
    load_word(5'd4, 32'hffff_ffff);
    add_ldi(5'd5, 16'h0001);
    add_alu(OP_ADD, 5'd4, 5'd5);
    v = $random(seed);
    load_word(5'd6, v);
    load_word(5'd7, v);
    add_alu(OP_SUB, 5'd6, 5'd7);
    shift_set(16'd0);
    shift_set(16'd1);
    shift_set(16'd31);
    shift_set(imm_t'($random(seed)));
    memory_test();
    // Spurious instr_valid while busy must not land
    poke_next = 1'b1;
    add_out(5'd2);
    add_out(5'd2);
    poke_next = 1'b1;
    add_alu(OP_XOR, 5'd4, 5'd5);
    add_out(5'd2);
    push_row(encode(6'h3f, 5'd2, 5'd3, 16'hffff), K_NONE, '0, '0, 1'b0);
    push_row(encode(6'h00, 5'd3, 5'd2, 16'h5555), K_NONE, '0, '0, 1'b0);
    add_out(5'd2);
    add_out(5'd3);
  endtask

  // Called at a falling edge and returns the bus of the last busy cycle
  task automatic wait_ready(output word_t last_bus);
    last_bus = bus;
    while (!ready) begin
      last_bus = bus;
      @(negedge clk);
    end
  endtask

  task automatic apply_row(input row_t r);
    word_t last_bus;
    wait_ready(last_bus);
    @(posedge clk);
    instr <= r.instr;
    instr_valid <= 1'b1;
    // Accept edge
    @(posedge clk);
    if (r.poke) begin
      instr <= poke_instr;
    end else begin
      instr_valid <= 1'b0;
    end
    @(negedge clk);
    check_bit("ready", ready, !r.busy);
    if (r.kind == K_WORD) begin
      while (!out_valid) @(negedge clk);
      check_word("bus", bus, r.exp_word);
    end
    if (r.poke) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      @(negedge clk);
    end
    wait_ready(last_bus);
    if (r.kind == K_WORD_FLAGS) begin
      check_word("bus (mlu writeback)", last_bus, r.exp_word);
      check_flags("flags", flags, r.exp_flags);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    build_table();
    cycle_limit = rows.size() * 8 + 100;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("ready", ready, 1'b1);
    check_bit("out_valid", out_valid, 1'b0);
    check_flags("flags", flags, 3'b000);
    check_word("bus", bus, '0);
    while (rows.size() > 0) begin
      apply_row(rows.pop_front());
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+verilog
verilog/kpu_pkg.sv
verilog/kpu_ctrl_if.sv
verilog/mlu.sv
verilog/register_file.sv
verilog/mmu.sv
verilog/datapath.sv
verilog/control_logic.sv
verilog/kpu.sv
sim/kpu_properties.sv
sim/kpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the kpu testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module kpu_tb -f filelist.f --Mdir obj_dir -o kpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/kpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0
